// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
logic/fsab_pkg.sv
logic/fsab_credit_counter.sv
logic/icache_array.sv
logic/icache_lookup.sv
logic/icache_fill_ctrl.sv
logic/icache_top.sv
tests/tb_clock_gen.sv
tests/icache_tb.sv

// ==== logic/fsab_credit_counter.sv ====
// Counts outbound bus credits for the instruction cache and flags when a request may be sent.
`timescale 1ns/1ps
`default_nettype none

module fsab_credit_counter import fsab_pkg::*; (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  spend, // Request sent this cycle.
	input  wire  give,  // Credit returned by the bus.
	output logic credit_avail
);

	logic [fsab_credits_w-1:0] count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= fsab_initial_credits;
		end else begin
			// A spend and a give in one cycle cancel out.
			case ({give, spend})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign credit_avail = (count != '0);

	// Fill control must hold its request while the pool is empty.
	spend_needs_credit: assert property (
		@(posedge clk) disable iff (!arst_n)
		spend |-> (count != '0)
	) else $error("Bus request sent with no credit left.");

	// The bus never returns more credits than were handed out.
	count_bounded: assert property (
		@(posedge clk) disable iff (!arst_n)
		count <= fsab_initial_credits
	) else $error("Credit count above its initial value.");

endmodule

`default_nettype wire

// ==== logic/fsab_pkg.sv ====
// Bus constants, cache geometry and packed bus structs shared by every instruction cache module.
`default_nettype none

package fsab_pkg;

	// Fetch address is split as tag [31:10], index [9:6], beat [5:3], half [2].
	localparam int ic_tag_w  = 22;
	localparam int ic_idx_w  = 4;
	localparam int ic_beat_w = 3;

	localparam int ic_lines = 16;
	localparam int ic_words = 128; // One entry per {line, beat}.

	// Bus field widths.
	localparam int fsab_addr_w = 31;
	localparam int fsab_data_w = 64;
	localparam int fsab_len_w  = 4;
	localparam int fsab_mask_w = 8;
	localparam int fsab_did_w  = 4;
	localparam int fsab_mode_w = 1;

	// Outbound credit pool.
	localparam int fsab_credits_w = 3;
	localparam logic [fsab_credits_w-1:0] fsab_initial_credits = 3'd4;

	localparam logic [fsab_mode_w-1:0] fsab_read = 1'b0;

	// IDs that replies must carry to be taken by this cache.
	localparam logic [fsab_did_w-1:0] fsab_did_cpu       = 4'h0;
	localparam logic [fsab_did_w-1:0] fsab_subdid_icache = 4'h1;

	localparam logic [fsab_len_w-1:0] ic_fill_len = 4'd8; // Beats per line.

	typedef logic [ic_tag_w-1:0]    ic_tag_t;
	typedef logic [fsab_data_w-1:0] ic_word_t;

	// Outbound request, qualified by a separate valid.
	typedef struct packed {
		logic [fsab_mode_w-1:0] mode;
		logic [fsab_did_w-1:0]  did;
		logic [fsab_did_w-1:0]  subdid;
		logic [fsab_addr_w-1:0] addr;
		logic [fsab_len_w-1:0]  len;
		logic [fsab_data_w-1:0] data;
		logic [fsab_mask_w-1:0] mask;
	} fsab_req_t;

	// Inbound reply beat.
	typedef struct packed {
		logic [fsab_did_w-1:0]  did;
		logic [fsab_did_w-1:0]  subdid;
		logic [fsab_data_w-1:0] data;
	} fsab_rsp_t;

endpackage

`default_nettype wire

// ==== logic/icache_array.sv ====
// Generic storage array for cache tags or line data, with combinational read and clocked write.
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
	parameter type payload_t = logic [31:0],
	parameter int  depth     = 16
) (
	input  wire                       clk,
	input  wire                       we,
	input  wire [$clog2(depth)-1:0]   waddr,
	input  wire payload_t             wdata,
	input  wire [$clog2(depth)-1:0]   raddr,
	output payload_t                  rdata
);

	// Contents are undefined until written; the valid bits in
	// the lookup block keep stale entries from being used.
	(* ram_style = "block" *) payload_t mem [depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read sees the old entry during a write to the same address.
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== logic/icache_fill_ctrl.sv ====
// Miss handling FSM that issues the line read and writes the returning beats, used by the cache top level.
`timescale 1ns/1ps
`default_nettype none

module icache_fill_ctrl import fsab_pkg::*; (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire [31:0]           rd_addr,
	input  wire                  rd_req,
	input  wire                  hit,
	input  wire                  credit_avail,
	input  wire                  bus_rsp_valid,
	input  wire fsab_rsp_t       bus_rsp,
	output logic                 bus_req_valid,
	output fsab_req_t            bus_req,
	output logic                 fill_we,
	output logic [ic_idx_w-1:0]  fill_idx,
	output logic [ic_beat_w-1:0] fill_beat,
	output ic_word_t             fill_word,
	output logic                 line_done,
	output ic_tag_t              fill_tag,
	output logic                 line_invalidate
);

	typedef enum logic {
		st_idle,
		st_fill
	} fill_state_t;

	fill_state_t                       state;
	logic [ic_tag_w+ic_idx_w-1:0]      line_addr; // Tag and index of the line in flight.
	logic [ic_beat_w-1:0]              beat_cnt;
	logic                              start_fill;
	logic                              rsp_match;

	// Only one miss at a time, and only with a credit in hand.
	assign start_fill = (state == st_idle) && rd_req && !hit && credit_avail;

	assign rsp_match = bus_rsp_valid
		&& (bus_rsp.did == fsab_did_cpu)
		&& (bus_rsp.subdid == fsab_subdid_icache);

	// Line-aligned burst read, issued in the miss cycle itself.
	always_comb begin
		bus_req        = '0;
		bus_req.mode   = fsab_read;
		bus_req.did    = fsab_did_cpu;
		bus_req.subdid = fsab_subdid_icache;
		bus_req.addr   = {rd_addr[30:6], 6'b000000};
		bus_req.len    = ic_fill_len;
	end

	assign bus_req_valid   = start_fill;
	assign line_invalidate = start_fill;

	// While idle the index comes straight from the core, so the
	// invalidate hits the right line before it is latched.
	assign fill_idx  = (state == st_idle) ? rd_addr[9:6] : line_addr[ic_idx_w-1:0];
	assign fill_tag  = line_addr[ic_tag_w+ic_idx_w-1:ic_idx_w];
	assign fill_beat = beat_cnt;
	assign fill_word = bus_rsp.data;
	assign fill_we   = (state == st_fill) && rsp_match;
	assign line_done = fill_we && (beat_cnt == '1); // Eighth beat.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			beat_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start_fill) begin
						state    <= st_fill;
						beat_cnt <= '0;
					end
				end
				st_fill: begin
					if (fill_we) begin
						beat_cnt <= beat_cnt + 1'b1;
					end
					if (line_done) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_fill) begin
			line_addr <= rd_addr[31:6];
		end
	end

	// Replies for this cache only come back for a burst it asked for.
	no_reply_when_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		rsp_match |-> (state == st_fill)
	) else $error("Reply beat for the cache with no fill in flight.");

endmodule

`default_nettype wire

// ==== logic/icache_lookup.sv ====
// Instruction cache lookup block with valid bits, tag and data arrays, hit detection and the read register, used by the cache top level.
`timescale 1ns/1ps
`default_nettype none

module icache_lookup import fsab_pkg::*; (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire [31:0]           rd_addr,
	input  wire                  fill_we,
	input  wire [ic_idx_w-1:0]   fill_idx,
	input  wire [ic_beat_w-1:0]  fill_beat,
	input  wire ic_word_t        fill_word,
	input  wire                  line_done,
	input  wire ic_tag_t         fill_tag,
	input  wire                  line_invalidate,
	output logic                 hit,
	output logic [31:0]          rd_data
);

	logic [ic_lines-1:0]  line_valid;
	ic_tag_t              rd_tag;
	logic [ic_idx_w-1:0]  rd_idx;
	logic [ic_beat_w-1:0] rd_beat;
	ic_tag_t              tag_rdata;
	ic_word_t             word_rdata;

	assign rd_tag  = rd_addr[31:10];
	assign rd_idx  = rd_addr[9:6];
	assign rd_beat = rd_addr[5:3];

	// Tag is written once per line, when the last beat lands.
	icache_array #(
		.payload_t (ic_tag_t),
		.depth     (ic_lines)
	) tag_array_inst (
		.clk   (clk),
		.we    (line_done),
		.waddr (fill_idx),
		.wdata (fill_tag),
		.raddr (rd_idx),
		.rdata (tag_rdata)
	);

	icache_array #(
		.payload_t (ic_word_t),
		.depth     (ic_words)
	) data_array_inst (
		.clk   (clk),
		.we    (fill_we),
		.waddr ({fill_idx, fill_beat}),
		.wdata (fill_word),
		.raddr ({rd_idx, rd_beat}),
		.rdata (word_rdata)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			line_valid <= '0;
		end else if (line_invalidate) begin
			line_valid[fill_idx] <= 1'b0; // Line is being refilled.
		end else if (line_done) begin
			line_valid[fill_idx] <= 1'b1;
		end
	end

	assign hit = line_valid[rd_idx] && (tag_rdata == rd_tag);

	// Word select by address bit 2, one cycle after lookup.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= rd_addr[2] ? word_rdata[63:32] : word_rdata[31:0];
		end
	end

	// Beats only land in a line that is marked invalid.
	fill_into_invalid_line: assert property (
		@(posedge clk) disable iff (!arst_n)
		fill_we |-> !line_valid[fill_idx]
	) else $error("Fill beat written into a line that is still valid.");

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
// Instruction cache top level, joining the core fetch port and the bus to the cache blocks.
`timescale 1ns/1ps
`default_nettype none

module icache_top import fsab_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,

	// Core fetch port.
	input  wire [31:0]      rd_addr,
	input  wire             rd_req,
	output logic            rd_wait,
	output logic [31:0]     rd_data,

	// Bus, outbound and inbound.
	output logic            bus_req_valid,
	output fsab_req_t       bus_req,
	input  wire             bus_credit,
	input  wire             bus_rsp_valid,
	input  wire fsab_rsp_t  bus_rsp
);

	logic                 hit;
	logic                 credit_avail;
	logic                 fill_we;
	logic [ic_idx_w-1:0]  fill_idx;
	logic [ic_beat_w-1:0] fill_beat;
	ic_word_t             fill_word;
	logic                 line_done;
	ic_tag_t              fill_tag;
	logic                 line_invalidate;

	// Stall the core for as long as the fetch misses.
	assign rd_wait = rd_req && !hit;

	fsab_credit_counter credit_counter_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.spend        (bus_req_valid),
		.give         (bus_credit),
		.credit_avail (credit_avail)
	);

	icache_lookup lookup_inst (
		.clk             (clk),
		.arst_n          (arst_n),
		.rd_addr         (rd_addr),
		.fill_we         (fill_we),
		.fill_idx        (fill_idx),
		.fill_beat       (fill_beat),
		.fill_word       (fill_word),
		.line_done       (line_done),
		.fill_tag        (fill_tag),
		.line_invalidate (line_invalidate),
		.hit             (hit),
		.rd_data         (rd_data)
	);

	icache_fill_ctrl fill_ctrl_inst (
		.clk             (clk),
		.arst_n          (arst_n),
		.rd_addr         (rd_addr),
		.rd_req          (rd_req),
		.hit             (hit),
		.credit_avail    (credit_avail),
		.bus_rsp_valid   (bus_rsp_valid),
		.bus_rsp         (bus_rsp),
		.bus_req_valid   (bus_req_valid),
		.bus_req         (bus_req),
		.fill_we         (fill_we),
		.fill_idx        (fill_idx),
		.fill_beat       (fill_beat),
		.fill_word       (fill_word),
		.line_done       (line_done),
		.fill_tag        (fill_tag),
		.line_invalidate (line_invalidate)
	);

endmodule

`default_nettype wire

// ==== tests/icache_cases.txt ====
// Columns: fetch address, expected hit (1) or miss (0) in the first request cycle, expected word.
// Addresses stay below 8000_0000, since the bus carries 31 address bits.
// First fills after reset, then hits in both halves of several beats.
00001000 0 00001000
00001004 1 FFFFEFFF
00001038 1 00001038
0000103C 1 FFFFEFC7
00001010 1 00001010
00001040 0 00001040
0000107C 1 FFFFEF87
00001000 1 00001000
// Same index, new tag, then the old line again.
00002000 0 00002000
00001000 0 00001000
00002008 0 00002008
0000200C 1 FFFFDFF7
00001044 1 FFFFEFBF
00003A80 0 00003A80
00003ABC 1 FFFFC547
00003A90 1 00003A90
12345678 0 12345678
1234567C 1 EDCBA987
12345640 1 12345640
7FFFFFC0 0 7FFFFFC0
7FFFFFFC 1 80000007
7FFFFFE4 1 8000001F
0000107C 1 FFFFEF87
00002004 1 FFFFDFFF
// Credits are held back from here, so the fifth miss starves.
00000080 0 00000080
000000C4 0 FFFFFF3F
00000100 0 00000100
0000014C 0 FFFFFEB7
00000180 0 00000180
000001C8 0 000001C8
// Lines filled before and during the stall still hit.
00000084 1 FFFFFF7F
000001CC 1 FFFFFE37
00001040 1 00001040
12345678 1 12345678
00005000 0 00005000
00002000 0 00002000

// ==== tests/icache_tb.sv ====
// Instruction cache testbench that replays fetches from the cases file against a credit-based bus model.
`timescale 1ns/1ps
`default_nettype none

module icache_tb import fsab_pkg::*; ();

	localparam int max_cases       = 64;
	localparam int cycles_per_case = 400;
	localparam int hold_case       = 24; // First case of the credit stall phase.
	localparam int stall_limit     = 12; // Starved cycles before credits flow again.

	logic        clk;
	logic        arst_n;
	logic [31:0] rd_addr;
	logic        rd_req;
	logic        rd_wait;
	logic [31:0] rd_data;
	logic        bus_req_valid;
	fsab_req_t   bus_req;
	logic        bus_credit    = 1'b0;
	logic        bus_rsp_valid = 1'b0;
	fsab_rsp_t   bus_rsp       = '0;

	logic [31:0] cases [3*max_cases]; // Address, hit flag, word per case.
	int          n_cases = 0;
	int          case_no = 0;
	integer      seed    = 32'h413a_fb43;

	// Bus memory model state.
	int          cycle         = 0;
	int          reqs_sent     = 0;
	int          credits_back  = 0;
	int          starve_cycles = 0;
	bit          credit_hold   = 1'b0;
	bit          stall_seen    = 1'b0;
	int          credit_due_q [$];
	logic [30:0] burst_q [$];
	logic [30:0] burst_base;
	logic [31:0] beat_addr;
	int          beats_left    = 0;
	int          beat_no       = 0;
	int          start_delay   = 0;

	tb_clock_gen clock_gen_inst (
		.clk    (clk),
		.arst_n (arst_n)
	);

	icache_top icache_top_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.rd_addr       (rd_addr),
		.rd_req        (rd_req),
		.rd_wait       (rd_wait),
		.rd_data       (rd_data),
		.bus_req_valid (bus_req_valid),
		.bus_req       (bus_req),
		.bus_credit    (bus_credit),
		.bus_rsp_valid (bus_rsp_valid),
		.bus_rsp       (bus_rsp)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped after a failed check.");
	endtask

	// Low half of a beat holds its byte address, high half the inverse.
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] beat_base;
		beat_base = {addr[31:3], 3'b000};
		return addr[2] ? ~beat_base : beat_base;
	endfunction

	// Request side of the model and the run timeout.
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > cycles_per_case * n_cases) begin
			report_failure($sformatf("Timeout after %0d cycles, the fetches never finished.",
				cycle));
		end
		assert (!bus_req_valid || (rd_req && rd_wait)) else
			report_failure($sformatf("error at %0t: bus request without a missing fetch", $time));
		if (bus_req_valid) begin
			assert (reqs_sent - credits_back < 4) else
				report_failure($sformatf("error at %0t: bus request sent with zero credits", $time));
			assert (bus_req.mode == fsab_read && bus_req.len == ic_fill_len
				&& bus_req.did == fsab_did_cpu && bus_req.subdid == fsab_subdid_icache) else
				report_failure($sformatf("error at %0t: bad request fields, len %0d", $time,
					bus_req.len));
			// Fetch address rounded down to its 64-byte line.
			assert (bus_req.addr == fsab_addr_w'((rd_addr / 64) * 64)) else
				report_failure($sformatf("error at %0t: request address %h for fetch %h", $time,
					bus_req.addr, rd_addr));
			burst_q.push_back(bus_req.addr);
			credit_due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 6));
			reqs_sent = reqs_sent + 1;
		end
		if (bus_credit) begin
			credits_back = credits_back + 1;
		end
		assert (reqs_sent - credits_back <= 4) else
			report_failure($sformatf("error at %0t: %0d requests outstanding", $time,
				reqs_sent - credits_back));
		if (rd_req && rd_wait && reqs_sent - credits_back == 4) begin
			starve_cycles = starve_cycles + 1;
		end
		// Hold credits back until a miss has starved for a while.
		if (!stall_seen && case_no >= hold_case) begin
			if (starve_cycles >= stall_limit) begin
				credit_hold = 1'b0;
				stall_seen  = 1'b1;
			end else begin
				credit_hold = 1'b1;
			end
		end
	end

	// Reply side with credit returns, line beats and foreign traffic.
	always @(negedge clk) begin
		bus_credit    = 1'b0;
		bus_rsp_valid = 1'b0;
		bus_rsp       = '0;
		if (!credit_hold && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
			void'(credit_due_q.pop_front());
			bus_credit = 1'b1;
		end
		if (beats_left == 0 && burst_q.size() != 0) begin
			burst_base  = burst_q.pop_front();
			beats_left  = 8;
			beat_no     = 0;
			start_delay = int'($unsigned($random(seed)) % 8);
		end
		if ($unsigned($random(seed)) % 4 == 0) begin
			bus_rsp_valid  = 1'b1; // Beat for another client.
			bus_rsp.did    = fsab_did_cpu;
			bus_rsp.subdid = fsab_subdid_icache + 4'd1;
			bus_rsp.data   = {$random(seed), $random(seed)};
		end else if (beats_left != 0) begin
			if (start_delay != 0) begin
				start_delay = start_delay - 1;
			end else begin
				beat_addr      = {1'b0, burst_base} + beat_no * 8;
				bus_rsp_valid  = 1'b1;
				bus_rsp.did    = fsab_did_cpu;
				bus_rsp.subdid = fsab_subdid_icache;
				bus_rsp.data   = {~beat_addr, beat_addr};
				beat_no        = beat_no + 1;
				beats_left     = beats_left - 1;
			end
		end
	end

	// One fetch that requests, waits out any miss and checks the word.
	task automatic run_case(input int n);
		logic [31:0] addr;
		logic        exp_hit;
		logic [31:0] exp_data;
		int          reqs_before;
		addr     = cases[3*n];
		exp_hit  = cases[3*n+1][0];
		exp_data = cases[3*n+2];
		assert (exp_data == expected_word(addr)) else
			report_failure($sformatf("Case %0d of the cases file has word %h, memory holds %h.",
				n, exp_data, expected_word(addr)));
		reqs_before = reqs_sent;
		rd_addr     = addr;
		rd_req      = 1'b1;
		@(posedge clk);
		assert (rd_wait == !exp_hit) else
			report_failure($sformatf("error at %0t: fetch %h gave wait %b, expected hit %b", $time,
				addr, rd_wait, exp_hit));
		while (rd_wait) begin
			@(posedge clk);
		end
		@(negedge clk);
		assert (rd_data == exp_data) else
			report_failure($sformatf("error at %0t: fetch %h read %h, expected %h", $time, addr,
				rd_data, exp_data));
		assert (reqs_sent - reqs_before == (exp_hit ? 0 : 1)) else
			report_failure($sformatf("error at %0t: fetch %h caused %0d bus requests", $time, addr,
				reqs_sent - reqs_before));
	endtask

	initial begin
		rd_addr = '0;
		rd_req  = 1'b0;
		for (int i = 0; i < 3*max_cases; i++) begin
			cases[i] = '1; // All ones marks the end of the list.
		end
		$readmemh("tests/icache_cases.txt", cases);
		while (n_cases < max_cases && cases[3*n_cases] != 32'hffff_ffff) begin
			n_cases = n_cases + 1;
		end
		assert (n_cases > hold_case) else
			report_failure("The cases file is too short for the credit stall phase.");
		wait (arst_n);
		repeat (3) @(negedge clk);
		for (int n = 0; n < n_cases; n++) begin
			case_no = n;
			run_case(n);
			if (n % 3 == 2) begin
				rd_req = 1'b0;
				repeat (2) @(negedge clk);
			end
		end
		rd_req = 1'b0;
		repeat (4) @(negedge clk);
		if (stall_seen) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_failure("The credit stall phase never ran the credit pool dry.");
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Clock and reset source for the instruction cache testbench with an 8 ns clock and two reset cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // Half of the 8 ns period.
	end

	// Reset covers two rising edges and lifts on a falling one.
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire
